/* rtl/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

////////////////////////////////////////////////////////////////////////
// field widths
////////////////////////////////////////////////////////////////////////
`define WORD_W      32
`define REG_ADDR_W  5
`define OP_W        6
`define FUNCT_W     6
`define IMM_W       16
`define SHAMT_W     5

////////////////////////////////////////////////////////////////////////
// primary opcodes, inst[31:26]
////////////////////////////////////////////////////////////////////////
`define OP_SPECIAL  6'b000000   // R-type, decoded further by funct
`define OP_ORI      6'b001101
`define OP_ANDI     6'b001100
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011

// function codes under OP_SPECIAL, inst[5:0]
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_MOVZ     6'b001010
`define FN_MOVN     6'b001011
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

`endif

/* rtl/idPkg.sv */
`default_nettype none

`include "mips_consts.svh"

package idPkg;

    typedef logic [`WORD_W-1:0]     wordT;
    typedef logic [`REG_ADDR_W-1:0] regAddrT;
    typedef logic [`WORD_W-1:0]     instT;

    // codes are fixed, the EX stage decodes them by value
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_OR   = 4'd1,
        ALU_AND  = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_ADD  = 4'd8,
        ALU_ADDU = 4'd9,
        ALU_SUB  = 4'd10,
        ALU_SUBU = 4'd11,
        ALU_SLT  = 4'd12,
        ALU_SLTU = 4'd13,
        ALU_MOVN = 4'd14,
        ALU_MOVZ = 4'd15
    } aluOpT;

    // how the 32-bit immediate is formed
    typedef enum logic [2:0] {
        IMM_NONE,       // immediate reads as zero
        IMM_ZERO_EXT,
        IMM_SIGN_EXT,
        IMM_UPPER,      // lui, field in bits 31:16
        IMM_SHAMT       // shift amount, zero-extended
    } immKindT;

    typedef enum logic [1:0] {
        WR_NEVER,
        WR_ALWAYS,
        WR_IF_NONZERO,  // movn
        WR_IF_ZERO      // movz
    } writeKindT;

endpackage

`default_nettype wire

/* rtl/idInterfaces.sv */
`default_nettype none

`include "mips_consts.svh"

// decoder to operand fetch, what the instruction needs
interface decodeCtrlIf;
    import idPkg::*;

    aluOpT                  aluOp;
    logic                   readEn1;
    logic                   readEn2;
    immKindT                immKind;
    logic [`IMM_W-1:0]      immField;   // raw inst[15:0]
    logic [`SHAMT_W-1:0]    shamtField; // raw inst[10:6]
    writeKindT              writeKind;
    regAddrT                writeAddr;
    logic                   instValid;

    modport dec (
        output aluOp, readEn1, readEn2, immKind, immField, shamtField,
        output writeKind, writeAddr, instValid
    );

    modport fetch (
        input aluOp, readEn1, readEn2, immKind, immField, shamtField,
        input writeKind, writeAddr, instValid
    );
endinterface

// resolved bundle into the ID/EX register
interface idExBus;
    import idPkg::*;

    aluOpT      aluOp;
    wordT       opNum1;
    wordT       opNum2;
    logic       writeReg;
    regAddrT    writeAddr;
    logic       instValid;

    modport src (output aluOp, opNum1, opNum2, writeReg, writeAddr, instValid);
    modport dst (input aluOp, opNum1, opNum2, writeReg, writeAddr, instValid);
endinterface

`default_nettype wire

/* rtl/instDecoder.sv */
`default_nettype none

`include "mips_consts.svh"

module instDecoder (
    input  idPkg::instT     inst,
    output idPkg::regAddrT  readAddr1,
    output idPkg::regAddrT  readAddr2,
    decodeCtrlIf.dec        ctrl
);
    import idPkg::*;

    logic [`OP_W-1:0]       op;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`SHAMT_W-1:0]    shamt;
    logic [`FUNCT_W-1:0]    funct;

    logic                   isImm;      // I-type form, writes rt
    logic                   isReg;      // R-type form, reads both
    writeKindT              regWrite;   // write rule for the R-type form

    assign op    = inst[31:26];
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign shamt = inst[10:6];
    assign funct = inst[5:0];

    // addresses go out even when the read is off
    assign readAddr1 = rs;
    assign readAddr2 = rt;

    assign ctrl.immField   = inst[15:0];
    assign ctrl.shamtField = shamt;

    always_comb
    begin
        //////////////////////////////////////////////////////////////////////
        // defaults give a NOP, each valid form overrides
        //////////////////////////////////////////////////////////////////////
        ctrl.aluOp     = ALU_NOP;
        ctrl.readEn1   = 1'b0;
        ctrl.readEn2   = 1'b0;
        ctrl.immKind   = IMM_NONE;
        ctrl.writeKind = WR_NEVER;
        ctrl.writeAddr = rd;
        ctrl.instValid = 1'b0;
        isImm          = 1'b0;
        isReg          = 1'b0;
        regWrite       = WR_ALWAYS;

        case (op)
            `OP_ORI:   begin ctrl.aluOp = ALU_OR;   ctrl.immKind = IMM_ZERO_EXT; isImm = 1'b1; end
            `OP_ANDI:  begin ctrl.aluOp = ALU_AND;  ctrl.immKind = IMM_ZERO_EXT; isImm = 1'b1; end
            `OP_XORI:  begin ctrl.aluOp = ALU_XOR;  ctrl.immKind = IMM_ZERO_EXT; isImm = 1'b1; end
            `OP_LUI:   begin ctrl.aluOp = ALU_OR;   ctrl.immKind = IMM_UPPER;    isImm = 1'b1; end
            `OP_ADDI:  begin ctrl.aluOp = ALU_ADD;  ctrl.immKind = IMM_SIGN_EXT; isImm = 1'b1; end
            `OP_ADDIU: begin ctrl.aluOp = ALU_ADDU; ctrl.immKind = IMM_SIGN_EXT; isImm = 1'b1; end
            `OP_SLTI:  begin ctrl.aluOp = ALU_SLT;  ctrl.immKind = IMM_SIGN_EXT; isImm = 1'b1; end
            `OP_SLTIU: begin ctrl.aluOp = ALU_SLTU; ctrl.immKind = IMM_SIGN_EXT; isImm = 1'b1; end
            `OP_SPECIAL:
            begin
                case (shamt)
                    '0:
                    begin
                        isReg = 1'b1;           // cleared again if funct is unknown
                        case (funct)
                            `FN_OR:   ctrl.aluOp = ALU_OR;
                            `FN_AND:  ctrl.aluOp = ALU_AND;
                            `FN_XOR:  ctrl.aluOp = ALU_XOR;
                            `FN_NOR:  ctrl.aluOp = ALU_NOR;
                            `FN_SLLV: ctrl.aluOp = ALU_SLL;
                            `FN_SRLV: ctrl.aluOp = ALU_SRL;
                            `FN_SRAV: ctrl.aluOp = ALU_SRA;
                            `FN_ADD:  ctrl.aluOp = ALU_ADD;
                            `FN_ADDU: ctrl.aluOp = ALU_ADDU;
                            `FN_SUB:  ctrl.aluOp = ALU_SUB;
                            `FN_SUBU: ctrl.aluOp = ALU_SUBU;
                            `FN_SLT:  ctrl.aluOp = ALU_SLT;
                            `FN_SLTU: ctrl.aluOp = ALU_SLTU;
                            `FN_MOVN:
                            begin
                                ctrl.aluOp = ALU_MOVN;
                                regWrite   = WR_IF_NONZERO;
                            end
                            `FN_MOVZ:
                            begin
                                ctrl.aluOp = ALU_MOVZ;
                                regWrite   = WR_IF_ZERO;
                            end
                            default: isReg = 1'b0;  // hi/lo ops land here too
                        endcase
                    end
                    default: ;                  // nonzero shamt is not an R-type op
                endcase
            end
            default: ;                          // unknown or dropped opcode
        endcase

        if (isImm)
        begin
            ctrl.readEn1   = 1'b1;
            ctrl.writeKind = WR_ALWAYS;
            ctrl.writeAddr = rt;
            ctrl.instValid = 1'b1;
        end

        if (isReg)
        begin
            ctrl.readEn1   = 1'b1;
            ctrl.readEn2   = 1'b1;
            ctrl.writeKind = regWrite;
            ctrl.instValid = 1'b1;
        end

        // shift by shamt, needs op and rs both zero
        if ({op, rs} == '0)
        begin
            case (funct)
                `FN_SLL,
                `FN_SRL,
                `FN_SRA:
                begin
                    ctrl.aluOp     = (funct == `FN_SLL) ? ALU_SLL :
                                     (funct == `FN_SRL) ? ALU_SRL : ALU_SRA;
                    ctrl.readEn1   = 1'b0;
                    ctrl.readEn2   = 1'b1;
                    ctrl.immKind   = IMM_SHAMT;
                    ctrl.writeKind = WR_ALWAYS;
                    ctrl.instValid = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/operandFetch.sv */
`default_nettype none

`include "mips_consts.svh"

module operandFetch (
    decodeCtrlIf.fetch  ctrl,
    input idPkg::wordT  regData1,
    input idPkg::wordT  regData2,
    idExBus.src         bus
);
    import idPkg::*;

    localparam int PadW      = `WORD_W - `IMM_W;
    localparam int ShamtPadW = `WORD_W - `SHAMT_W;

    wordT imm;
    logic rtZero;

    ////////////////////////////////////////////////////////////////////////
    // immediate build
    ////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        case (ctrl.immKind)
            IMM_ZERO_EXT: imm = {{PadW{1'b0}}, ctrl.immField};
            IMM_SIGN_EXT: imm = {{PadW{ctrl.immField[`IMM_W-1]}}, ctrl.immField};
            IMM_UPPER:    imm = {ctrl.immField, {PadW{1'b0}}};
            IMM_SHAMT:    imm = {{ShamtPadW{1'b0}}, ctrl.shamtField};
            default:      imm = '0;
        endcase
    end

    // disabled read port takes the immediate
    assign bus.opNum1 = ctrl.readEn1 ? regData1 : imm;
    assign bus.opNum2 = ctrl.readEn2 ? regData2 : imm;

    ////////////////////////////////////////////////////////////////////////
    // write enable, movn/movz depend on rt data
    ////////////////////////////////////////////////////////////////////////
    assign rtZero = (regData2 == '0);

    always_comb
    begin
        case (ctrl.writeKind)
            WR_ALWAYS:     bus.writeReg = 1'b1;
            WR_IF_NONZERO: bus.writeReg = !rtZero;
            WR_IF_ZERO:    bus.writeReg = rtZero;
            default:       bus.writeReg = 1'b0;
        endcase
    end

    assign bus.aluOp     = ctrl.aluOp;
    assign bus.writeAddr = ctrl.writeAddr;
    assign bus.instValid = ctrl.instValid;

endmodule

`default_nettype wire

/* rtl/idExReg.sv */
`default_nettype none

module idExReg (
    input  logic            clk,
    input  logic            rstN,
    idExBus.dst             bus,
    output idPkg::aluOpT    exAluOp,
    output idPkg::wordT     exOpNum1,
    output idPkg::wordT     exOpNum2,
    output logic            exWriteReg,
    output idPkg::regAddrT  exWriteAddr,
    output logic            exInstValid
);
    import idPkg::*;

    ////////////////////////////////////////////////////////////////////////
    // ID/EX stage register, one instruction per edge, no stall
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            // NOP bundle
            exAluOp     <= ALU_NOP;
            exOpNum1    <= '0;
            exOpNum2    <= '0;
            exWriteReg  <= 1'b0;
            exWriteAddr <= '0;
            exInstValid <= 1'b0;
        end
        else
        begin
            exAluOp     <= bus.aluOp;
            exOpNum1    <= bus.opNum1;
            exOpNum2    <= bus.opNum2;
            exWriteReg  <= bus.writeReg;
            exWriteAddr <= bus.writeAddr;
            exInstValid <= bus.instValid;   // low marks an illegal instruction
        end
    end

endmodule

`default_nettype wire

/* rtl/idStage.sv */
`default_nettype none

module idStage (
    input  logic            clk,
    input  logic            rstN,
    input  idPkg::instT     inst,

    // register file read side, data comes back in the same cycle
    input  idPkg::wordT     regData1,
    input  idPkg::wordT     regData2,
    output logic            readEn1,
    output idPkg::regAddrT  readAddr1,
    output logic            readEn2,
    output idPkg::regAddrT  readAddr2,

    // towards EX
    output idPkg::aluOpT    exAluOp,
    output idPkg::wordT     exOpNum1,
    output idPkg::wordT     exOpNum2,
    output logic            exWriteReg,
    output idPkg::regAddrT  exWriteAddr,
    output logic            exInstValid
);

    decodeCtrlIf ctrlBus ();
    idExBus      exBus ();

    instDecoder uDecoder (
        .inst       (inst),
        .readAddr1  (readAddr1),
        .readAddr2  (readAddr2),
        .ctrl       (ctrlBus.dec)
    );

    operandFetch uFetch (
        .ctrl       (ctrlBus.fetch),
        .regData1   (regData1),
        .regData2   (regData2),
        .bus        (exBus.src)
    );

    idExReg uIdEx (
        .clk         (clk),
        .rstN        (rstN),
        .bus         (exBus.dst),
        .exAluOp     (exAluOp),
        .exOpNum1    (exOpNum1),
        .exOpNum2    (exOpNum2),
        .exWriteReg  (exWriteReg),
        .exWriteAddr (exWriteAddr),
        .exInstValid (exInstValid)
    );

    // read enables are combinational from inst
    assign readEn1 = ctrlBus.readEn1;
    assign readEn2 = ctrlBus.readEn2;

endmodule

`default_nettype wire

/* tests/tbClock.sv */
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;         // release away from the edge
    end

    always #2 clk = ~clk;       // 4 ns period

endmodule

`default_nettype wire

/* tests/idStageTb.sv */
`default_nettype none

module idStageTb;
    timeunit 1ns;
    timeprecision 100ps;

    // one line of the vector file
    typedef struct {
        logic [31:0] inst;
        logic [31:0] data1;
        logic [31:0] data2;
        logic        rdEn1;
        logic [4:0]  rdAddr1;
        logic        rdEn2;
        logic [4:0]  rdAddr2;
        logic [3:0]  aluOp;
        logic [31:0] opNum1;
        logic [31:0] opNum2;
        logic        wrReg;
        logic [4:0]  wrAddr;
        logic        valid;
    } vecT;

    logic        clk;
    logic        rstN;
    logic [31:0] inst;
    logic [31:0] regData1;
    logic [31:0] regData2;
    logic        readEn1;
    logic        readEn2;
    logic [4:0]  readAddr1;
    logic [4:0]  readAddr2;
    logic [3:0]  exAluOp;
    logic [31:0] exOpNum1;
    logic [31:0] exOpNum2;
    logic        exWriteReg;
    logic [4:0]  exWriteAddr;
    logic        exInstValid;

    vecT    vecs[$];
    int     numVec = 0;
    int     errors = 0;
    int     testsRun = 0;
    int     testsFailed = 0;
    logic   loadDone = 1'b0;
    integer seed = 32'h22b5_2d4f;
    string  testName = "";

    tbClock clkGen (.clk(clk), .rstN(rstN));

    idStage DUT (.*);

    task automatic compareValue(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0.1f ns: %s %s is %h, expected %h",
                     $realtime, testName, what, got, exp);
            errors++;
        end
    endtask

    task automatic loadVectors();
        integer fd;
        string  line;
        vecT    v;
        int     n;
        fd = $fopen("tests/idStage_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open tests/idStage_input.txt, no vectors were run");
            errors++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")   // skip comments and blanks
                begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                v.inst, v.data1, v.data2, v.rdEn1, v.rdAddr1, v.rdEn2,
                                v.rdAddr2, v.aluOp, v.opNum1, v.opNum2, v.wrReg,
                                v.wrAddr, v.valid);
                    if (n == 13)
                        vecs.push_back(v);
                    else
                    begin
                        $display("vector file has a malformed line: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // a port that is not read gets a random word that must not leak through
    task automatic applyVector(input vecT v);
        inst     = v.inst;
        regData1 = v.rdEn1 ? v.data1 : $random(seed);
        regData2 = v.rdEn2 ? v.data2 : $random(seed);
    endtask

    task automatic checkResetState();
        compareValue("exAluOp", 32'(exAluOp), 32'd0);
        compareValue("exOpNum1", exOpNum1, 32'd0);
        compareValue("exOpNum2", exOpNum2, 32'd0);
        compareValue("exWriteReg", 32'(exWriteReg), 32'd0);
        compareValue("exWriteAddr", 32'(exWriteAddr), 32'd0);
        compareValue("exInstValid", 32'(exInstValid), 32'd0);
    endtask

    task automatic reportTest(input int errsBefore);
        testsRun++;
        if (errors == errsBefore)
            $display("%s: ok", testName);
        else
        begin
            testsFailed++;
            $display("%s: FAILED", testName);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////
    initial
    begin
        int errsBefore;
        inst     = '0;
        regData1 = '0;
        regData2 = '0;
        loadVectors();
        numVec   = vecs.size();
        loadDone = 1'b1;
        if (numVec == 0)
        begin
            $display("no vectors were loaded");
            errors++;
        end

        // a valid ori sits on inst during reset
        testName   = "reset";
        errsBefore = errors;
        inst       = 32'h3423_8001;
        regData1   = $random(seed);
        regData2   = $random(seed);
        repeat (2)
        begin
            @(posedge clk);
            #0.5;
            checkResetState();
        end
        wait (rstN);
        #0.5;
        checkResetState();                  // released before the next edge
        reportTest(errsBefore);

        @(posedge clk);
        #1;
        foreach (vecs[i])
        begin
            testName   = $sformatf("vector %0d (inst %h)", i, vecs[i].inst);
            errsBefore = errors;
            applyVector(vecs[i]);
            #2;
            compareValue("readEn1", 32'(readEn1), 32'(vecs[i].rdEn1));
            compareValue("readAddr1", 32'(readAddr1), 32'(vecs[i].rdAddr1));
            compareValue("readEn2", 32'(readEn2), 32'(vecs[i].rdEn2));
            compareValue("readAddr2", 32'(readAddr2), 32'(vecs[i].rdAddr2));
            @(posedge clk);
            #0.5;
            compareValue("exAluOp", 32'(exAluOp), 32'(vecs[i].aluOp));
            compareValue("exOpNum1", exOpNum1, vecs[i].opNum1);
            compareValue("exOpNum2", exOpNum2, vecs[i].opNum2);
            compareValue("exWriteReg", 32'(exWriteReg), 32'(vecs[i].wrReg));
            if (vecs[i].wrReg)              // address only matters on a write
                compareValue("exWriteAddr", 32'(exWriteAddr), 32'(vecs[i].wrAddr));
            compareValue("exInstValid", 32'(exInstValid), 32'(vecs[i].valid));
            reportTest(errsBefore);
            #0.5;
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 testsRun, testsRun - testsFailed, testsFailed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // watchdog allows one cycle per vector plus slack for reset
    initial
    begin
        wait (loadDone);
        #((numVec + 10) * 4);
        $display("timeout: the run did not end within %0d clock cycles", numVec + 10);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/idStage_input.txt */
# inst regData1 regData2 | readEn1 readAddr1 readEn2 readAddr2 | aluOp opNum1 opNum2
# writeReg writeAddr instValid; all hex, data of a port that is not read is randomized
34238001 12345678 00000000 1 01 0 03 1 12345678 00008001 1 03 1
3044ff00 a5a5a5a5 00000000 1 02 0 04 2 a5a5a5a5 0000ff00 1 04 1
38c51234 0f0f0f0f 00000000 1 06 0 05 3 0f0f0f0f 00001234 1 05 1
3c07beef 00000000 00000000 1 00 0 07 1 00000000 beef0000 1 07 1
2128fffc 00000010 00000000 1 09 0 08 8 00000010 fffffffc 1 08 1
256a7fff 7fffffff 00000000 1 0b 0 0a 9 7fffffff 00007fff 1 0a 1
29ac8000 80000000 00000000 1 0d 0 0c c 80000000 ffff8000 1 0c 1
2dee0001 ffffffff 00000000 1 0f 0 0e d ffffffff 00000001 1 0e 1
00221825 11110000 00002222 1 01 1 02 1 11110000 00002222 1 03 1
016c5027 00000000 00000001 1 0b 1 0c 4 00000000 00000001 1 0a 1
01ee6804 00000004 0000000f 1 0f 1 0e 5 00000004 0000000f 1 0d 1
00853007 0000001f f0000000 1 04 1 05 7 0000001f f0000000 1 06 1
02328020 7fffffff 00000001 1 11 1 12 8 7fffffff 00000001 1 10 1
035bc823 00000000 00000001 1 1a 1 1b b 00000000 00000001 1 19 1
0022f82b 80000000 00000001 1 01 1 02 d 80000000 00000001 1 1f 1
00021900 00000000 00000001 0 00 1 02 5 00000004 00000001 1 03 1
00073403 00000000 ffff0000 0 00 1 07 7 00000010 ffff0000 1 06 1
00221900 00000000 00000000 0 01 0 02 0 00000000 00000000 0 03 0
0022180b cafef00d 00000001 1 01 1 02 e cafef00d 00000001 1 03 1
0022180b cafef00d 00000000 1 01 1 02 e cafef00d 00000000 0 03 1
0022180a 0badf00d 00000000 1 01 1 02 f 0badf00d 00000000 1 03 1
0022180a 0badf00d 80000000 1 01 1 02 f 0badf00d 80000000 0 03 1
00220018 00000000 00000000 0 01 0 02 0 00000000 00000000 0 00 0
00001810 00000000 00000000 0 00 0 00 0 00000000 00000000 0 03 0
70231820 00000000 00000000 0 01 0 03 0 00000000 00000000 0 03 0
70221802 00000000 00000000 0 01 0 02 0 00000000 00000000 0 03 0
02328060 00000000 00000000 0 11 0 12 0 00000000 00000000 0 10 0
fc221234 00000000 00000000 0 01 0 02 0 00000000 00000000 0 02 0

/* all.f */
+incdir+rtl
rtl/idPkg.sv
rtl/idInterfaces.sv
rtl/instDecoder.sv
rtl/operandFetch.sv
rtl/idExReg.sv
rtl/idStage.sv
tests/tbClock.sv
tests/idStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/100ps \
    --top-module idStageTb -f all.f -Mdir "$OBJ" -o simIdStage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/simIdStage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "Something failed" "$LOG"
status=$?
if [ $status -eq 0 ]; then
    exit 1
elif [ $status -ne 1 ]; then
    echo "could not search $LOG"
    exit 1
fi
exit 0
